//--- build.f
+incdir+include
hdl/wrb_pkg.sv
hdl/wrb_dual_port_ram.sv
hdl/wrb_slot_allocator.sv
hdl/wrb_id_queue.sv
hdl/wrb_release_arbiter.sv
hdl/wrb_bank.sv
tests/tb_wrb_bank.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the write-response bank testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module tb_wrb_bank \
  -Mdir obj_dir -o tb_wrb_bank
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_wrb_bank
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished without errors"
exit 0

//--- tests/tb_wrb_bank.sv
`default_nettype none

`include "wrb_config.svh"

module tb_wrb_bank
  import wrb_pkg::*;
();

  localparam int NumIds     = `WRB_NUM_IDS;
  localparam int Capacity   = `WRB_CAPACITY;
  localparam int IdWidth    = `WRB_ID_WIDTH;
  localparam int DriveDelay = 2;
  localparam int Timeout    = 50;

  logic       clk_i;
  logic       rst_ni;
  id_vec_t    rsv_id_onehot_i;
  logic       rsv_ready_i;
  logic       rsv_valid_o;
  bank_addr_t rsv_addr_o;
  msg_t       in_data_i;
  logic       in_valid_i;
  logic       in_ready_o;
  slot_vec_t  release_en_i;
  logic       out_ready_i;
  logic       out_valid_o;
  msg_t       out_data_o;
  slot_vec_t  released_onehot_o;

  // Reference model: reserved slots and stored messages per ID, oldest first
  bank_addr_t rsv_q [NumIds][$];
  msg_t       msg_q [NumIds][$];
  slot_vec_t  slot_used;
  int         seed;

  wrb_bank i_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .rsv_id_onehot_i  (rsv_id_onehot_i),
    .rsv_ready_i      (rsv_ready_i),
    .rsv_valid_o      (rsv_valid_o),
    .rsv_addr_o       (rsv_addr_o),
    .in_data_i        (in_data_i),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .release_en_i     (release_en_i),
    .out_ready_i      (out_ready_i),
    .out_valid_o      (out_valid_o),
    .out_data_o       (out_data_o),
    .released_onehot_o(released_onehot_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  // Inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  function automatic int lowest_free();
    int result;
    result = -1;
    for (int i = Capacity - 1; i >= 0; i--) begin
      if (!slot_used[i]) begin
        result = i;
      end
    end
    return result;
  endfunction

  // Reserved slots of an ID that still wait for a message
  function automatic int room(input int id);
    return rsv_q[id].size() - msg_q[id].size();
  endfunction

  function automatic int pick_room(input int start);
    int id;
    id = -1;
    for (int i = NumIds - 1; i >= 0; i--) begin
      if (room((start + i) % NumIds) > 0) begin
        id = (start + i) % NumIds;
      end
    end
    return id;
  endfunction

  function automatic int pending_total();
    int total;
    total = 0;
    for (int i = 0; i < NumIds; i++) begin
      total += msg_q[i].size();
    end
    return total;
  endfunction

  task automatic reserve(input int id);
    int waited;
    waited = 0;
    rsv_id_onehot_i = id_vec_t'(1) << id;
    rsv_ready_i     = 1'b1;
    @(negedge clk_i);
    while (!rsv_valid_o) begin
      waited++;
      if (waited > Timeout) fail_run("bank never offered a free slot for a reservation");
      @(negedge clk_i);
    end
    check("rsv_addr_o", rsv_addr_o, lowest_free());
    rsv_q[id].push_back(rsv_addr_o);
    slot_used[rsv_addr_o] = 1'b1;
    next_cycle();
    rsv_ready_i     = 1'b0;
    rsv_id_onehot_i = '0;
  endtask

  task automatic send_msg(input int id);
    msg_t msg;
    int   waited;
    msg              = msg_t'($random(seed));
    msg[IdWidth-1:0] = id_t'(id);
    waited           = 0;
    in_data_i        = msg;
    in_valid_i       = 1'b1;
    @(negedge clk_i);
    while (!in_ready_o) begin
      waited++;
      if (waited > Timeout) fail_run("bank never accepted a message with a reserved slot");
      @(negedge clk_i);
    end
    msg_q[id].push_back(msg);
    next_cycle();
    in_valid_i = 1'b0;
  endtask

  // Takes n messages and checks each against the front of its ID's list
  task automatic collect(input int n);
    int         waited;
    int         id;
    bank_addr_t addr;
    out_ready_i = 1'b1;
    for (int k = 0; k < n; k++) begin
      waited = 0;
      @(negedge clk_i);
      while (!out_valid_o) begin
        waited++;
        if (waited > Timeout) fail_run("an enabled message was never released");
        @(negedge clk_i);
      end
      id = int'(out_data_o[IdWidth-1:0]);
      if (msg_q[id].size() == 0) fail_run("message released for an ID with nothing stored");
      addr = rsv_q[id].pop_front();
      check("out_data_o", out_data_o, msg_q[id].pop_front());
      check("released_onehot_o", released_onehot_o, slot_vec_t'(1) << addr);
      slot_used[addr] = 1'b0;
      next_cycle();
    end
    out_ready_i = 1'b0;
  endtask

  task automatic expect_idle(input int cycles);
    for (int k = 0; k < cycles; k++) begin
      @(negedge clk_i);
      check("out_valid_o", out_valid_o, 0);
      check("released_onehot_o", released_onehot_o, 0);
      next_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_after_reset();
    in_data_i = '0;
    @(negedge clk_i);
    check("rsv_valid_o", rsv_valid_o, 1);
    check("out_valid_o", out_valid_o, 0);
    check("rsv_addr_o", rsv_addr_o, 0);
    check("in_ready_o", in_ready_o, 0);
    check("released_onehot_o", released_onehot_o, 0);
    next_cycle();
  endtask

  task automatic test_input_acceptance();
    // ID 1 has no slot yet
    in_data_i = msg_t'(1);
    @(negedge clk_i);
    check("in_ready_o", in_ready_o, 0);
    next_cycle();
    reserve(1);
    @(negedge clk_i);
    check("in_ready_o", in_ready_o, 1);
    next_cycle();
    send_msg(1);
    @(negedge clk_i);
    check("in_ready_o", in_ready_o, 0);
    next_cycle();
    release_en_i = '1;
    collect(1);
    release_en_i = '0;
  endtask

  task automatic test_release_order();
    for (int k = 0; k < 4; k++) begin
      reserve(2);
    end
    for (int k = 0; k < 4; k++) begin
      send_msg(2);
    end
    expect_idle(4);
    // Second slot alone is not enough, the oldest blocks it
    release_en_i = slot_vec_t'(1) << rsv_q[2][1];
    expect_idle(4);
    release_en_i = '1;
    collect(4);
    release_en_i = '0;
  endtask

  task automatic test_backpressure();
    msg_t held;
    int   waited;
    reserve(3);
    reserve(0);
    send_msg(3);
    send_msg(0);
    // Only the ID 3 slot is enabled at first
    release_en_i = slot_vec_t'(1) << rsv_q[3][0];
    waited       = 0;
    @(negedge clk_i);
    while (!out_valid_o) begin
      waited++;
      if (waited > Timeout) fail_run("stalled output never became valid");
      @(negedge clk_i);
    end
    held = out_data_o;
    for (int k = 0; k < 6; k++) begin
      next_cycle();
      // Lower ID becomes eligible while the output is stalled
      release_en_i = '1;
      @(negedge clk_i);
      check("out_valid_o", out_valid_o, 1);
      check("out_data_o", out_data_o, held);
      check("released_onehot_o", released_onehot_o, 0);
    end
    next_cycle();
    collect(2);
    release_en_i = '0;
  endtask

  task automatic test_capacity();
    for (int k = 0; k < Capacity; k++) begin
      reserve(k % NumIds);
      check("reserved address", rsv_q[k % NumIds][$], k);
    end
    @(negedge clk_i);
    check("rsv_valid_o", rsv_valid_o, 0);
    next_cycle();
    for (int k = 0; k < Capacity; k++) begin
      send_msg(k % NumIds);
    end
    release_en_i = '1;
    collect(Capacity);
    release_en_i = '0;
  endtask

  task automatic test_interleaved();
    int id;
    int turn;
    turn = 0;
    for (int s = 0; s < 12; s++) begin
      reserve((s * 3) % NumIds);
      if (s % 2 == 1) begin
        id = pick_room(s);
        if (id >= 0) send_msg(id);
      end
      // Drain midway so later reservations reuse freed slots
      if (s == 5) begin
        release_en_i = '1;
        collect(pending_total());
        release_en_i = '0;
      end
    end
    id = pick_room(turn);
    while (id >= 0) begin
      send_msg(id);
      turn++;
      id = pick_room(turn);
    end
    release_en_i = '1;
    collect(pending_total());
    release_en_i = '0;
    @(negedge clk_i);
    check("rsv_valid_o", rsv_valid_o, 1);
    check("rsv_addr_o", rsv_addr_o, 0);
    check("out_valid_o", out_valid_o, 0);
    next_cycle();
  endtask

  initial begin
    seed            = 32'h2470;
    slot_used       = '0;
    rst_ni          = 1'b0;
    rsv_id_onehot_i = '0;
    rsv_ready_i     = 1'b0;
    in_data_i       = '0;
    in_valid_i      = 1'b0;
    release_en_i    = '0;
    out_ready_i     = 1'b0;
    repeat (5) @(posedge clk_i);
    #DriveDelay;
    rst_ni = 1'b1;

    test_after_reset();
    test_input_acceptance();
    test_release_order();
    test_backpressure();
    test_capacity();
    test_interleaved();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/wrb_bank.sv
`default_nettype none

`include "wrb_config.svh"

module wrb_bank
  import wrb_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire id_vec_t   rsv_id_onehot_i,
  input  wire            rsv_ready_i,
  output logic           rsv_valid_o,
  output bank_addr_t     rsv_addr_o,
  input  wire msg_t      in_data_i,
  input  wire            in_valid_i,
  output logic           in_ready_o,
  input  wire slot_vec_t release_en_i,
  input  wire            out_ready_i,
  output logic           out_valid_o,
  output msg_t           out_data_o,
  output slot_vec_t      released_onehot_o
);

  localparam int NumIds = `WRB_NUM_IDS;

  logic       rsv_fire;
  logic       in_fire;
  logic       out_fire;
  id_t        in_id;
  id_vec_t    in_id_onehot;
  id_vec_t    has_room;
  id_vec_t    pending;
  id_vec_t    pop_onehot;
  bank_addr_t free_addr;
  logic       any_free;

  logic       q_link_wr_en   [NumIds];
  bank_addr_t q_link_wr_addr [NumIds];
  bank_addr_t q_link_wr_data [NumIds];
  logic       q_link_rd_en   [NumIds];
  bank_addr_t q_link_rd_addr [NumIds];
  bank_addr_t q_fill_addr    [NumIds];
  bank_addr_t candidate_addr [NumIds];
  bank_addr_t pend_count     [NumIds];
  bank_addr_t rsv_count      [NumIds];

  logic       link_wr_en;
  bank_addr_t link_wr_addr;
  bank_addr_t link_wr_data;
  logic       link_rd_en;
  bank_addr_t link_rd_addr;
  bank_addr_t link_rd_data;
  bank_addr_t msg_wr_addr;
  logic       msg_rd_en;
  bank_addr_t msg_rd_addr;

  //////////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////////

  assign in_id        = in_data_i[$bits(id_t)-1:0];
  assign in_id_onehot = id_vec_t'(1) << in_id;

  assign rsv_valid_o = any_free;
  assign rsv_addr_o  = free_addr;
  assign rsv_fire    = rsv_valid_o && rsv_ready_i;
  assign out_fire    = out_valid_o && out_ready_i;

  // Input waits while a release owns the link read port
  assign in_ready_o = has_room[in_id] && !out_fire;
  assign in_fire    = in_valid_i && in_ready_o;

  wrb_slot_allocator i_allocator (
    .clk_i,
    .rst_ni,
    .reserve_i       (rsv_fire),
    .release_i       (out_fire),
    .release_onehot_i(released_onehot_o),
    .free_addr_o     (free_addr),
    .any_free_o      (any_free)
  );

  for (genvar g = 0; g < NumIds; g++) begin : gen_queue
    wrb_id_queue i_queue (
      .clk_i,
      .rst_ni,
      .reserve_i       (rsv_fire && rsv_id_onehot_i[g]),
      .new_addr_i      (free_addr),
      .accept_i        (in_fire && in_id_onehot[g]),
      .pop_i           (pop_onehot[g]),
      .link_rd_data_i  (link_rd_data),
      .link_wr_en_o    (q_link_wr_en[g]),
      .link_wr_addr_o  (q_link_wr_addr[g]),
      .link_wr_data_o  (q_link_wr_data[g]),
      .link_rd_en_o    (q_link_rd_en[g]),
      .link_rd_addr_o  (q_link_rd_addr[g]),
      .fill_addr_o     (q_fill_addr[g]),
      .candidate_addr_o(candidate_addr[g]),
      .pending_count_o (pend_count[g]),
      .reserved_count_o(rsv_count[g])
    );
  end

  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      has_room[i] = rsv_count[i] != '0;
      pending[i]  = pend_count[i] != '0;
    end
  end

  // At most one queue drives each RAM port in a cycle
  always_comb begin
    link_wr_en   = 1'b0;
    link_wr_addr = '0;
    link_wr_data = '0;
    link_rd_en   = 1'b0;
    link_rd_addr = '0;
    msg_wr_addr  = '0;
    for (int i = 0; i < NumIds; i++) begin
      link_wr_en   = link_wr_en | q_link_wr_en[i];
      link_wr_addr = link_wr_addr | q_link_wr_addr[i];
      link_wr_data = link_wr_data | q_link_wr_data[i];
      link_rd_en   = link_rd_en | q_link_rd_en[i];
      link_rd_addr = link_rd_addr | q_link_rd_addr[i];
      msg_wr_addr  = msg_wr_addr | q_fill_addr[i];
    end
  end

  wrb_release_arbiter i_arbiter (
    .clk_i,
    .rst_ni,
    .release_en_i,
    .candidate_addr_i (candidate_addr),
    .pending_i        (pending),
    .out_ready_i,
    .pop_onehot_o     (pop_onehot),
    .msg_rd_en_o      (msg_rd_en),
    .msg_rd_addr_o    (msg_rd_addr),
    .out_valid_o,
    .released_onehot_o
  );

  //////////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////////

  wrb_dual_port_ram #(
    .payload_t(msg_t),
    .Depth    (`WRB_CAPACITY)
  ) i_msg_ram (
    .clk_i,
    .wr_en_i  (in_fire),
    .wr_addr_i(msg_wr_addr),
    .wr_data_i(in_data_i),
    .rd_en_i  (msg_rd_en),
    .rd_addr_i(msg_rd_addr),
    .rd_data_o(out_data_o)
  );

  wrb_dual_port_ram #(
    .payload_t(bank_addr_t),
    .Depth    (`WRB_CAPACITY)
  ) i_link_ram (
    .clk_i,
    .wr_en_i  (link_wr_en),
    .wr_addr_i(link_wr_addr),
    .wr_data_i(link_wr_data),
    .rd_en_i  (link_rd_en),
    .rd_addr_i(link_rd_addr),
    .rd_data_o(link_rd_data)
  );

  // Arbiter hold and RAM read data together keep a stalled output steady
  out_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

`default_nettype wire

//--- hdl/wrb_release_arbiter.sv
`default_nettype none

`include "wrb_config.svh"

module wrb_release_arbiter
  import wrb_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire slot_vec_t  release_en_i,
  input  wire bank_addr_t candidate_addr_i [`WRB_NUM_IDS],
  input  wire id_vec_t    pending_i,
  input  wire             out_ready_i,
  output id_vec_t         pop_onehot_o,
  output logic            msg_rd_en_o,
  output bank_addr_t      msg_rd_addr_o,
  output logic            out_valid_o,
  output slot_vec_t       released_onehot_o
);

  localparam int NumIds = `WRB_NUM_IDS;

  id_vec_t   eligible;
  id_vec_t   pick;
  id_vec_t   sel_id_q;
  slot_vec_t sel_slot_q;
  logic      out_valid_q;
  logic      handshake;

  // Eligible when the oldest filled slot of the ID is enabled
  always_comb begin
    for (int i = 0; i < NumIds; i++) begin
      eligible[i] = pending_i[i] && release_en_i[candidate_addr_i[i]];
    end
  end

  // Lowest eligible ID
  assign pick = eligible & (~eligible + id_vec_t'(1));

  always_comb begin
    msg_rd_addr_o = '0;
    for (int i = 0; i < NumIds; i++) begin
      if (pick[i]) begin
        msg_rd_addr_o = msg_rd_addr_o | candidate_addr_i[i];
      end
    end
  end

  assign handshake = out_valid_q && out_ready_i;

  // Selection is frozen while a message waits at the output
  assign msg_rd_en_o = !out_valid_q && (eligible != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
      sel_id_q    <= '0;
      sel_slot_q  <= '0;
    end else if (msg_rd_en_o) begin
      out_valid_q <= 1'b1;
      sel_id_q    <= pick;
      sel_slot_q  <= slot_vec_t'(1) << msg_rd_addr_o;
    end else if (handshake) begin
      out_valid_q <= 1'b0;
    end
  end

  assign out_valid_o       = out_valid_q;
  assign pop_onehot_o      = handshake ? sel_id_q : '0;
  assign released_onehot_o = handshake ? sel_slot_q : '0;

endmodule

`default_nettype wire

//--- hdl/wrb_id_queue.sv
`default_nettype none

module wrb_id_queue
  import wrb_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire             reserve_i,
  input  wire bank_addr_t new_addr_i,
  input  wire             accept_i,
  input  wire             pop_i,
  input  wire bank_addr_t link_rd_data_i,
  output logic            link_wr_en_o,
  output bank_addr_t      link_wr_addr_o,
  output bank_addr_t      link_wr_data_o,
  output logic            link_rd_en_o,
  output bank_addr_t      link_rd_addr_o,
  output bank_addr_t      fill_addr_o,
  output bank_addr_t      candidate_addr_o,
  output bank_addr_t      pending_count_o,
  output bank_addr_t      reserved_count_o
);

  // Counters must reach the full capacity when one ID holds every slot
  localparam int CntWidth = $clog2($bits(slot_vec_t) + 1);
  typedef logic [CntWidth-1:0] cnt_t;
  localparam cnt_t MaxOutCount = cnt_t'({$bits(bank_addr_t){1'b1}});

  bank_addr_t head_d;
  bank_addr_t head_q;
  bank_addr_t middle_d;
  bank_addr_t middle_q;
  bank_addr_t middle;
  bank_addr_t tail_d;
  bank_addr_t tail_q;
  bank_addr_t tail;
  logic       middle_from_ram_q;
  logic       tail_from_ram_q;
  cnt_t       rsv_cnt_d;
  cnt_t       rsv_cnt_q;
  cnt_t       pend_cnt_d;
  cnt_t       pend_cnt_q;
  cnt_t       rsv_left;
  logic       empty_box;
  logic       list_live;
  logic       fill_read;
  logic       pop_read;

  //////////////////////////////////////////////////////////////////////////
  // Pointer view
  //////////////////////////////////////////////////////////////////////////

  // Middle and tail take the link RAM output one cycle after a read
  assign middle = middle_from_ram_q ? link_rd_data_i : middle_q;
  assign tail   = tail_from_ram_q ? link_rd_data_i : tail_q;

  assign rsv_left = accept_i ? rsv_cnt_q - 1'b1 : rsv_cnt_q;

  // Empty box: middle has caught up with the head and no empty slot is left
  assign empty_box = (rsv_left == '0);

  // Some slot stays in the list past this cycle's pop
  assign list_live = (rsv_cnt_q != '0) || (pend_cnt_q > cnt_t'(pop_i));

  // A successor is only read once it is already linked
  assign fill_read = accept_i && (rsv_cnt_q > cnt_t'(1));
  assign pop_read  = pop_i && (pend_cnt_q > cnt_t'(1));

  //////////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    head_d     = head_q;
    middle_d   = middle;
    tail_d     = tail;
    rsv_cnt_d  = rsv_cnt_q;
    pend_cnt_d = pend_cnt_q;

    if (reserve_i) begin
      head_d    = new_addr_i;
      rsv_cnt_d = rsv_cnt_d + 1'b1;
      // New slot is the next one to fill
      if (empty_box) begin
        middle_d = new_addr_i;
      end
    end

    if (accept_i) begin
      rsv_cnt_d  = rsv_cnt_d - 1'b1;
      pend_cnt_d = pend_cnt_d + 1'b1;
      // First filled slot becomes the tail
      if (pend_cnt_q == '0) begin
        tail_d = middle;
      end
    end

    if (pop_i) begin
      pend_cnt_d = pend_cnt_d - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // RAM requests
  //////////////////////////////////////////////////////////////////////////

  // Idle requests are zero so the top level can OR all queues together
  assign link_wr_en_o   = reserve_i && list_live;
  assign link_wr_addr_o = link_wr_en_o ? head_q : '0;
  assign link_wr_data_o = link_wr_en_o ? new_addr_i : '0;
  assign link_rd_en_o   = fill_read || pop_read;
  assign link_rd_addr_o = pop_read ? tail : (fill_read ? middle : '0);
  assign fill_addr_o    = accept_i ? middle : '0;

  assign candidate_addr_o = tail;

  // Saturate so a full bank still reads as nonzero
  assign pending_count_o  = (pend_cnt_q > MaxOutCount) ? '1 : bank_addr_t'(pend_cnt_q);
  assign reserved_count_o = (rsv_cnt_q > MaxOutCount) ? '1 : bank_addr_t'(rsv_cnt_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q            <= '0;
      middle_q          <= '0;
      tail_q            <= '0;
      middle_from_ram_q <= 1'b0;
      tail_from_ram_q   <= 1'b0;
      rsv_cnt_q         <= '0;
      pend_cnt_q        <= '0;
    end else begin
      head_q            <= head_d;
      middle_q          <= middle_d;
      tail_q            <= tail_d;
      middle_from_ram_q <= fill_read;
      tail_from_ram_q   <= pop_read;
      rsv_cnt_q         <= rsv_cnt_d;
      pend_cnt_q        <= pend_cnt_d;
    end
  end

  // Arbiter pops only filled slots and never while a fill shares the link port
  pop_filled_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pop_i |-> (pend_cnt_q != '0) && !accept_i);

endmodule

`default_nettype wire

//--- hdl/wrb_slot_allocator.sv
`default_nettype none

module wrb_slot_allocator
  import wrb_pkg::*;
(
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire            reserve_i,
  input  wire            release_i,
  input  wire slot_vec_t release_onehot_i,
  output bank_addr_t     free_addr_o,
  output logic           any_free_o
);

  localparam int NumSlots = $bits(slot_vec_t);

  slot_vec_t valid_d;
  slot_vec_t valid_q;

  // Priority encoder, lowest free slot wins
  always_comb begin
    free_addr_o = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_addr_o = bank_addr_t'(i);
      end
    end
  end

  assign any_free_o = ~&valid_q;

  always_comb begin
    valid_d = valid_q;
    // Released slot goes back to the pool
    if (release_i) begin
      valid_d = valid_d & ~release_onehot_i;
    end
    if (reserve_i) begin
      valid_d[free_addr_o] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // Only a slot handed out earlier can come back
  release_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      release_i |-> $onehot(release_onehot_i) && ((release_onehot_i & valid_q) != '0));

endmodule

`default_nettype wire

//--- hdl/wrb_dual_port_ram.sv
`default_nettype none

`include "wrb_config.svh"

module wrb_dual_port_ram
  import wrb_pkg::*;
#(
  parameter type         payload_t = msg_t,
  parameter int unsigned Depth     = `WRB_CAPACITY
) (
  input  wire             clk_i,
  input  wire             wr_en_i,
  input  wire bank_addr_t wr_addr_i,
  input  wire payload_t   wr_data_i,
  input  wire             rd_en_i,
  input  wire bank_addr_t rd_addr_i,
  output payload_t        rd_data_o
);

  payload_t mem_q [Depth];

  // Full-width write on the write port
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Registered read
  // Data stays put between reads
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

  // The queues never touch one slot from both ports in the same cycle
  no_same_slot_a: assert property (@(posedge clk_i)
      !(wr_en_i && rd_en_i && (wr_addr_i == rd_addr_i)));

endmodule

`default_nettype wire

//--- hdl/wrb_pkg.sv
`default_nettype none

`include "wrb_config.svh"

package wrb_pkg;

  localparam int unsigned BankAddrWidth = $clog2(`WRB_CAPACITY);

  // Slot index, shared by the message RAM and the link RAM
  typedef logic [BankAddrWidth-1:0] bank_addr_t;

  // Transaction ID
  typedef logic [`WRB_ID_WIDTH-1:0] id_t;

  // Stored message, ID in the low bits
  typedef logic [`WRB_MSG_WIDTH-1:0] msg_t;

  // One bit per slot
  typedef logic [`WRB_CAPACITY-1:0] slot_vec_t;

  // One bit per ID
  typedef logic [`WRB_NUM_IDS-1:0] id_vec_t;

endpackage

`default_nettype wire

//--- include/wrb_config.svh
`ifndef WRB_CONFIG_SVH
`define WRB_CONFIG_SVH

// Number of message slots in the bank
`define WRB_CAPACITY 16

// Transaction ID width
// The ID sits in the low bits of every message
`define WRB_ID_WIDTH 2

// Message width including the ID field
`define WRB_MSG_WIDTH 16

// One queue per ID
`define WRB_NUM_IDS (1 << `WRB_ID_WIDTH)

`endif
